//--- hw/addr_pipeline.sv
// -----------------------------------------------
// Source index pipeline and pointer generation.
// Four free-running stages; the result is valid
// four cycles after the position settles.
// -----------------------------------------------
`default_nettype none

module addr_pipeline
  import im2col_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     pipe_clr_i,
  input  logic     out_ptr_step_i,
  input  logic     out_ptr_load_i,
  input  size_t    zeros_left_i,
  input  size_t    zeros_top_i,
  conv_cfg_if.snk  cfg,
  patch_pos_if.rcv pos,
  output ptr_t     in_ptr_o,
  output ptr_t     out_ptr_o
);

  idx_t row_off, col_off;  // Signed offsets, two's complement.
  idx_t idx_s1_q, idx_s2_q, idx_s3_q, idx_s4_q;
  idx_t index;
  ptr_t out_inc;

  assign row_off = IDX_W'(pos.h_offset) - IDX_W'(cfg.pad_top);
  assign col_off = IDX_W'(pos.w_offset) - IDX_W'(cfg.pad_left);

  // ---------------------------------------------
  // Index stages.
  // ---------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      idx_s1_q <= '0;
      idx_s2_q <= '0;
      idx_s3_q <= '0;
      idx_s4_q <= '0;
    end else if (pipe_clr_i) begin
      idx_s1_q <= '0;
      idx_s2_q <= '0;
      idx_s3_q <= '0;
      idx_s4_q <= '0;
    end else begin
      idx_s1_q <= IDX_W'(pos.batch_idx) * IDX_W'(cfg.num_ch) + IDX_W'(pos.im_c);
      idx_s2_q <= idx_s1_q * IDX_W'(cfg.ih);                        // Plane base row.
      idx_s3_q <= idx_s2_q + row_off + IDX_W'(zeros_top_i);         // First valid row.
      idx_s4_q <= idx_s3_q * IDX_W'(cfg.iw) + col_off;
    end
  end

  assign index    = idx_s4_q + IDX_W'(zeros_left_i);
  assign in_ptr_o = cfg.src_ptr + PTR_W'(index << ELEM_BYTES_LOG2);

  // One output patch plane per descriptor.
  assign out_inc = (PTR_W'(cfg.n_patches_h) * PTR_W'(cfg.n_patches_w)) << ELEM_BYTES_LOG2;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_ptr_o <= '0;
    end else if (out_ptr_load_i) begin
      out_ptr_o <= cfg.dst_ptr;
    end else if (out_ptr_step_i) begin
      out_ptr_o <= out_ptr_o + out_inc;
    end
  end

endmodule

`default_nettype wire

//--- hw/conv_cfg_if.sv
// -----------------------------------------------
// Convolution configuration bundle. All fields
// must stay stable from start until done.
// -----------------------------------------------
`default_nettype none

interface conv_cfg_if
  import im2col_pkg::*;
#(
  parameter int unsigned DIM_W = 8
);

  ptr_t             src_ptr, dst_ptr;
  size_t            iw, ih;                  // Image size.
  size_t            n_patches_w, n_patches_h;
  logic [DIM_W-1:0] fw, fh;                  // Filter size.
  logic [DIM_W-1:0] num_ch, batch, ch_col;
  logic [DIM_W-1:0] pad_left, pad_right, pad_top, pad_bottom;

  modport src (
    output src_ptr, dst_ptr, iw, ih, n_patches_w, n_patches_h,
    output fw, fh, num_ch, batch, ch_col, pad_left, pad_right, pad_top, pad_bottom
  );

  modport snk (
    input src_ptr, dst_ptr, iw, ih, n_patches_w, n_patches_h,
    input fw, fh, num_ch, batch, ch_col, pad_left, pad_right, pad_top, pad_bottom
  );

endinterface

`default_nettype wire

//--- hw/im2col_param_top.sv
// -----------------------------------------------
// im2col parameter generator top level. No
// handshake: a descriptor is pushed on a one-cycle
// strobe, and the FIFO needs one entry of slack.
// Configuration must hold from start until done.
// -----------------------------------------------
`default_nettype none

module im2col_param_top
  import im2col_pkg::*;
#(
  parameter int unsigned DIM_W = 8
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             start_i,
  input  logic             fifo_full_i,
  input  ptr_t             src_ptr_i,
  input  ptr_t             dst_ptr_i,
  input  size_t            iw_i,
  input  size_t            ih_i,
  input  size_t            n_patches_w_i,
  input  size_t            n_patches_h_i,
  input  logic [DIM_W-1:0] fw_i,
  input  logic [DIM_W-1:0] fh_i,
  input  logic [DIM_W-1:0] num_ch_i,
  input  logic [DIM_W-1:0] batch_i,
  input  logic [DIM_W-1:0] ch_col_i,
  input  logic [DIM_W-1:0] pad_left_i,
  input  logic [DIM_W-1:0] pad_right_i,
  input  logic [DIM_W-1:0] pad_top_i,
  input  logic [DIM_W-1:0] pad_bottom_i,
  output logic             fifo_push_o,
  output logic             done_o,
  output ptr_t             desc_in_ptr_o,
  output ptr_t             desc_out_ptr_o,
  output size_t            desc_in_inc_d2_o,
  output size_t            desc_size_d1_o,
  output size_t            desc_size_d2_o,
  output logic [DIM_W-1:0] desc_zeros_left_o,
  output logic [DIM_W-1:0] desc_zeros_right_o,
  output logic [DIM_W-1:0] desc_zeros_top_o,
  output logic [DIM_W-1:0] desc_zeros_bottom_o
);

  conv_cfg_if  #(.DIM_W(DIM_W)) cfg ();
  patch_pos_if #(.DIM_W(DIM_W)) pos ();

  logic  zeros_clr, zeros_ph1, zeros_ph2;
  logic  batch_inc, batch_clr, pos_step;
  logic  out_ptr_step, out_ptr_load, pipe_clr;
  logic  batch_last, run_last;
  size_t zeros_left_ext, zeros_top_ext;

  // ---------------------------------------------
  // Configuration bus.
  // ---------------------------------------------
  assign cfg.src_ptr     = src_ptr_i;
  assign cfg.dst_ptr     = dst_ptr_i;
  assign cfg.iw          = iw_i;
  assign cfg.ih          = ih_i;
  assign cfg.n_patches_w = n_patches_w_i;
  assign cfg.n_patches_h = n_patches_h_i;
  assign cfg.fw          = fw_i;
  assign cfg.fh          = fh_i;
  assign cfg.num_ch      = num_ch_i;
  assign cfg.batch       = batch_i;
  assign cfg.ch_col      = ch_col_i;
  assign cfg.pad_left    = pad_left_i;
  assign cfg.pad_right   = pad_right_i;
  assign cfg.pad_top     = pad_top_i;
  assign cfg.pad_bottom  = pad_bottom_i;

  assign zeros_left_ext = size_t'(desc_zeros_left_o);
  assign zeros_top_ext  = size_t'(desc_zeros_top_o);

  param_sequencer i_seq (
    .clk_i, .rst_ni, .start_i, .fifo_full_i,
    .batch_last_i   (batch_last),
    .run_last_i     (run_last),
    .fifo_push_o, .done_o,
    .zeros_clr_o    (zeros_clr),
    .zeros_ph1_o    (zeros_ph1),
    .zeros_ph2_o    (zeros_ph2),
    .batch_inc_o    (batch_inc),
    .batch_clr_o    (batch_clr),
    .pos_step_o     (pos_step),
    .out_ptr_step_o (out_ptr_step),
    .out_ptr_load_o (out_ptr_load),
    .pipe_clr_o     (pipe_clr)
  );

  window_counter #(.DIM_W(DIM_W)) i_win (
    .clk_i, .rst_ni,
    .batch_inc_i  (batch_inc),
    .batch_clr_i  (batch_clr),
    .pos_step_i   (pos_step),
    .cfg          (cfg),
    .pos          (pos),
    .batch_last_o (batch_last),
    .run_last_o   (run_last)
  );

  pad_calc #(.DIM_W(DIM_W)) i_pad (
    .clk_i, .rst_ni,
    .zeros_clr_i    (zeros_clr),
    .zeros_ph1_i    (zeros_ph1),
    .zeros_ph2_i    (zeros_ph2),
    .cfg            (cfg),
    .pos            (pos),
    .zeros_left_o   (desc_zeros_left_o),
    .zeros_right_o  (desc_zeros_right_o),
    .zeros_top_o    (desc_zeros_top_o),
    .zeros_bottom_o (desc_zeros_bottom_o),
    .size_d1_o      (desc_size_d1_o),
    .size_d2_o      (desc_size_d2_o),
    .in_inc_d2_o    (desc_in_inc_d2_o)
  );

  addr_pipeline i_addr (
    .clk_i, .rst_ni,
    .pipe_clr_i     (pipe_clr),
    .out_ptr_step_i (out_ptr_step),
    .out_ptr_load_i (out_ptr_load),
    .zeros_left_i   (zeros_left_ext),
    .zeros_top_i    (zeros_top_ext),
    .cfg            (cfg),
    .pos            (pos),
    .in_ptr_o       (desc_in_ptr_o),
    .out_ptr_o      (desc_out_ptr_o)
  );

endmodule

`default_nettype wire

//--- hw/im2col_pkg.sv
// -----------------------------------------------
// Shared widths and types of the im2col parameter
// generator. Elements are 4 bytes wide and only
// stride 1 is supported.
// -----------------------------------------------
`default_nettype none

package im2col_pkg;

  localparam int unsigned PTR_W           = 32;  // Byte address width.
  localparam int unsigned SIZE_W          = 16;  // Transfer sizes and patch counts.
  localparam int unsigned IDX_W           = 32;  // Element index width.
  localparam int unsigned ELEM_BYTES_LOG2 = 2;

  typedef logic [PTR_W-1:0]  ptr_t;
  typedef logic [SIZE_W-1:0] size_t;
  typedef logic [IDX_W-1:0]  idx_t;

  // Descriptor sequencer phases.
  typedef enum logic [3:0] {
    IDLE,
    PRECOMP,
    COND_EVAL,
    ZEROS_1,
    ZEROS_2,
    ZEROS_3,
    INDEX_1,
    INDEX_2,
    INDEX_3,
    PUSH,
    OUT_PTR_UPDATE,
    OFFSET_UPDATE
  } seq_state_e;

endpackage

`default_nettype wire

//--- hw/pad_calc.sv
// -----------------------------------------------
// Zero-padding counts and transfer sizes. Stride 1
// only; right and bottom use the plain pad values.
// -----------------------------------------------
`default_nettype none

module pad_calc
  import im2col_pkg::*;
#(
  parameter int unsigned DIM_W = 8
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             zeros_clr_i,
  input  logic             zeros_ph1_i,
  input  logic             zeros_ph2_i,
  conv_cfg_if.snk          cfg,
  patch_pos_if.rcv         pos,
  output logic [DIM_W-1:0] zeros_left_o,
  output logic [DIM_W-1:0] zeros_right_o,
  output logic [DIM_W-1:0] zeros_top_o,
  output logic [DIM_W-1:0] zeros_bottom_o,
  output size_t            size_d1_o,
  output size_t            size_d2_o,
  output size_t            in_inc_d2_o
);

  logic [DIM_W-1:0] fw_rem_q, fh_rem_q;  // Distance to the far filter edge.

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fw_rem_q       <= '0;
      fh_rem_q       <= '0;
      zeros_left_o   <= '0;
      zeros_right_o  <= '0;
      zeros_top_o    <= '0;
      zeros_bottom_o <= '0;
    end else if (zeros_clr_i) begin
      fw_rem_q       <= '0;
      fh_rem_q       <= '0;
      zeros_left_o   <= '0;
      zeros_right_o  <= '0;
      zeros_top_o    <= '0;
      zeros_bottom_o <= '0;
    end else begin
      if (zeros_ph1_i) begin
        fw_rem_q <= cfg.fw - DIM_W'(1) - pos.w_offset;
        fh_rem_q <= cfg.fh - DIM_W'(1) - pos.h_offset;
      end
      if (zeros_ph2_i) begin
        zeros_left_o   <= (cfg.pad_left > pos.w_offset) ? cfg.pad_left - pos.w_offset : '0;
        zeros_top_o    <= (cfg.pad_top > pos.h_offset) ? cfg.pad_top - pos.h_offset : '0;
        zeros_right_o  <= (cfg.pad_right > fw_rem_q) ? cfg.pad_right - fw_rem_q : '0;
        zeros_bottom_o <= (cfg.pad_bottom > fh_rem_q) ? cfg.pad_bottom - fh_rem_q : '0;
      end
    end
  end

  assign size_d1_o   = cfg.n_patches_w - SIZE_W'(zeros_left_o) - SIZE_W'(zeros_right_o);
  assign size_d2_o   = cfg.n_patches_h - SIZE_W'(zeros_top_o) - SIZE_W'(zeros_bottom_o);
  // Jump from the end of one row to the start of the next.
  assign in_inc_d2_o = cfg.iw - (size_d1_o - SIZE_W'(1));

endmodule

`default_nettype wire

//--- hw/param_sequencer.sv
// -----------------------------------------------
// Descriptor sequencer. One descriptor takes nine
// cycles without back-pressure. The FIFO needs one
// entry of slack since full is sampled in INDEX_3.
// -----------------------------------------------
`default_nettype none

module param_sequencer
  import im2col_pkg::*;
(
  input  logic clk_i,
  input  logic rst_ni,
  input  logic start_i,
  input  logic fifo_full_i,
  input  logic batch_last_i,
  input  logic run_last_i,
  output logic fifo_push_o,
  output logic done_o,
  output logic zeros_clr_o,
  output logic zeros_ph1_o,
  output logic zeros_ph2_o,
  output logic batch_inc_o,
  output logic batch_clr_o,
  output logic pos_step_o,
  output logic out_ptr_step_o,
  output logic out_ptr_load_o,
  output logic pipe_clr_o
);

  seq_state_e state_q, state_d;
  logic       done_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == IDLE && start_i) begin
        done_q <= 1'b0;
      end else if (state_q == OFFSET_UPDATE && run_last_i) begin
        done_q <= 1'b1;                          // Last descriptor already pushed.
      end
    end
  end

  // -----------------------------------------------
  // Next state and per-phase enables.
  // -----------------------------------------------
  always_comb begin
    state_d        = state_q;
    fifo_push_o    = 1'b0;
    zeros_clr_o    = 1'b0;
    zeros_ph1_o    = 1'b0;
    zeros_ph2_o    = 1'b0;
    batch_inc_o    = 1'b0;
    batch_clr_o    = 1'b0;
    pos_step_o     = 1'b0;
    out_ptr_step_o = 1'b0;
    out_ptr_load_o = 1'b0;
    pipe_clr_o     = 1'b0;
    unique case (state_q)
      IDLE: begin
        batch_clr_o    = 1'b1;
        zeros_clr_o    = 1'b1;
        out_ptr_load_o = 1'b1;
        pipe_clr_o     = 1'b1;
        if (start_i) state_d = PRECOMP;
      end
      PRECOMP: begin
        batch_clr_o    = 1'b1;
        zeros_clr_o    = 1'b1;
        out_ptr_load_o = 1'b1;
        state_d        = COND_EVAL;
      end
      COND_EVAL: state_d = ZEROS_1;
      ZEROS_1: begin
        zeros_ph1_o = 1'b1;
        state_d     = ZEROS_2;
      end
      ZEROS_2: begin
        zeros_ph2_o = 1'b1;
        state_d     = ZEROS_3;
      end
      ZEROS_3: state_d = INDEX_1;
      INDEX_1: state_d = INDEX_2;
      INDEX_2: state_d = INDEX_3;
      INDEX_3: begin
        if (!fifo_full_i) state_d = PUSH;        // Hold while the FIFO is full.
      end
      PUSH: begin
        fifo_push_o = 1'b1;
        state_d     = OUT_PTR_UPDATE;
      end
      OUT_PTR_UPDATE: begin
        batch_inc_o    = 1'b1;
        out_ptr_step_o = 1'b1;
        state_d        = batch_last_i ? OFFSET_UPDATE : COND_EVAL;
      end
      OFFSET_UPDATE: begin
        batch_clr_o = 1'b1;
        pos_step_o  = 1'b1;
        state_d     = run_last_i ? IDLE : COND_EVAL;
      end
      default: state_d = IDLE;
    endcase
  end

  assign done_o = done_q;

endmodule

`default_nettype wire

//--- hw/patch_pos_if.sv
// -----------------------------------------------
// Current window position from the loop counters.
// -----------------------------------------------
`default_nettype none

interface patch_pos_if #(
  parameter int unsigned DIM_W = 8
);

  logic [DIM_W-1:0] w_offset;
  logic [DIM_W-1:0] h_offset;
  logic [DIM_W-1:0] im_c;       // Input channel.
  logic [DIM_W-1:0] batch_idx;

  modport drv (output w_offset, h_offset, im_c, batch_idx);

  modport rcv (input w_offset, h_offset, im_c, batch_idx);

endinterface

`default_nettype wire

//--- hw/window_counter.sv
// -----------------------------------------------
// Loop counters over window offset, channel,
// channel-column and batch. ch_col is expected to
// equal fw * fh * num_ch.
// -----------------------------------------------
`default_nettype none

module window_counter #(
  parameter int unsigned DIM_W = 8
) (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   batch_inc_i,
  input  logic   batch_clr_i,
  input  logic   pos_step_i,
  conv_cfg_if.snk cfg,
  patch_pos_if.drv pos,
  output logic   batch_last_o,
  output logic   run_last_o
);

  logic [DIM_W-1:0] ch_col_q;
  logic             w_wrap, h_wrap, col_last;

  assign w_wrap   = (pos.w_offset == cfg.fw - DIM_W'(1));
  assign h_wrap   = (pos.h_offset == cfg.fh - DIM_W'(1));
  assign col_last = (ch_col_q == cfg.ch_col - DIM_W'(1));

  assign batch_last_o = (pos.batch_idx == cfg.batch - DIM_W'(1));
  // All batches of the last channel-column have been counted.
  assign run_last_o   = col_last && (pos.batch_idx == cfg.batch);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pos.w_offset <= '0;
      pos.h_offset <= '0;
      pos.im_c     <= '0;
      ch_col_q     <= '0;
    end else if (pos_step_i) begin
      if (run_last_o) begin
        pos.w_offset <= '0;                      // Run finished.
        pos.h_offset <= '0;
        pos.im_c     <= '0;
        ch_col_q     <= '0;
      end else begin
        ch_col_q     <= ch_col_q + DIM_W'(1);
        pos.w_offset <= w_wrap ? '0 : pos.w_offset + DIM_W'(1);
        if (w_wrap) begin
          pos.h_offset <= h_wrap ? '0 : pos.h_offset + DIM_W'(1);
          if (h_wrap) pos.im_c <= pos.im_c + DIM_W'(1);  // Every fh * fw steps.
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pos.batch_idx <= '0;
    end else if (batch_clr_i) begin
      pos.batch_idx <= '0;
    end else if (batch_inc_i) begin
      pos.batch_idx <= pos.batch_idx + DIM_W'(1);
    end
  end

endmodule

`default_nettype wire

//--- im2col_param.f
hw/im2col_pkg.sv
hw/conv_cfg_if.sv
hw/patch_pos_if.sv
hw/param_sequencer.sv
hw/window_counter.sv
hw/pad_calc.sv
hw/addr_pipeline.sv
hw/im2col_param_top.sv
tb/im2col_param_properties.sv
tb/tb_im2col_param.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the im2col parameter generator testbench with Verilator.
# The exit status is zero only when the pass line shows up in the output.

cd "$(dirname "$0")" &&
verilator --binary --assert \
  --top-module tb_im2col_param \
  -f im2col_param.f \
  -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -F -x -- "*** TEST PASSED ***" > /dev/null &&
echo "Simulation passed." ||
{
  echo "Simulation failed."
  exit 1
}

//--- tb/im2col_param_properties.sv
// -----------------------------------------------
// Push protocol checks bound to the top level.
// -----------------------------------------------
`default_nettype none

module im2col_param_properties (
  input logic clk_i,
  input logic rst_ni,
  input logic fifo_full_i,
  input logic fifo_push_o,
  input logic done_o
);

  int fail_cnt = 0;  // Number of failed assertions.

  // A push needs a free FIFO in the cycle before it.
  a_push_after_free: assert property (
    @(posedge clk_i) disable iff (!rst_ni) fifo_push_o |-> !$past(fifo_full_i)
  ) else begin
    fail_cnt++;
    $error("Descriptor pushed after a cycle with the FIFO full.");
  end

  a_single_push: assert property (
    @(posedge clk_i) disable iff (!rst_ni) fifo_push_o |=> !fifo_push_o
  ) else begin
    fail_cnt++;
    $error("Push strobe held high for two cycles.");
  end

  a_quiet_after_reset: assert property (
    @(posedge clk_i) $rose(rst_ni) |-> (!fifo_push_o && !done_o)
  ) else begin
    fail_cnt++;
    $error("Push or done high in the first cycle after reset.");
  end

endmodule

bind im2col_param_top im2col_param_properties i_props (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .fifo_full_i (fifo_full_i),
  .fifo_push_o (fifo_push_o),
  .done_o      (done_o)
);

`default_nettype wire

//--- tb/tb_im2col_param.sv
// -----------------------------------------------
// Testbench for the im2col parameter generator.
// Runs an unpadded case, a padded 3x3 case and the
// padded case again under random FIFO full.
// -----------------------------------------------
`default_nettype none

module tb_im2col_param;

  localparam int N_DESC = 1 * 1 * 1 * 2 + 2 * (3 * 3 * 2 * 2);  // Descriptors of all runs.
  localparam int LIMIT  = N_DESC * 12 * 4 + 200;

  typedef struct packed {
    logic [31:0] in_ptr, out_ptr;
    logic [15:0] inc_d2, size_d1, size_d2;
    logic [7:0]  left, right, top, bottom;
  } desc_t;

  logic        clk_i, rst_ni, start_i, fifo_full_i, fifo_push_o, done_o;
  logic [31:0] src_ptr_i, dst_ptr_i, desc_in_ptr_o, desc_out_ptr_o;
  logic [15:0] iw_i, ih_i, n_patches_w_i, n_patches_h_i;
  logic [15:0] desc_in_inc_d2_o, desc_size_d1_o, desc_size_d2_o;
  logic [7:0]  fw_i, fh_i, num_ch_i, batch_i, ch_col_i;
  logic [7:0]  pad_left_i, pad_right_i, pad_top_i, pad_bottom_i;
  logic [7:0]  desc_zeros_left_o, desc_zeros_right_o, desc_zeros_top_o, desc_zeros_bottom_o;

  desc_t       exp_q[$];
  desc_t       exp_d;
  logic [31:0] rng;
  logic        full_prev;
  int          errors, checks, push_cnt, cycle_cnt;

  im2col_param_top #(.DIM_W(8)) i_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_true(input bit cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("Error at %0t: %s", $time, what);
    end
  endtask

  task automatic set_config(input int f, input int nch, input int nb, input int pad,
                            input int img, input logic [31:0] src, input logic [31:0] dst);
    fw_i          = 8'(f);
    fh_i          = 8'(f);
    num_ch_i      = 8'(nch);
    batch_i       = 8'(nb);
    ch_col_i      = 8'(f * f * nch);    // One step per filter tap and channel.
    pad_left_i    = 8'(pad);
    pad_right_i   = 8'(pad);
    pad_top_i     = 8'(pad);
    pad_bottom_i  = 8'(pad);
    iw_i          = 16'(img);
    ih_i          = 16'(img);
    n_patches_w_i = 16'(img);
    n_patches_h_i = 16'(img);
    src_ptr_i     = src;
    dst_ptr_i     = dst;
  endtask

  // -----------------------------------------------
  // Reference model over channel-columns and batch.
  // -----------------------------------------------
  task automatic build_expected();
    int w, h, c, k, col, b, fw, fh, lf, rt, tp, bt, d1, d2, row, idx;
    desc_t d;
    w = 0;
    h = 0;
    c = 0;
    k = 0;
    fw = int'(fw_i);
    fh = int'(fh_i);
    exp_q.delete();
    for (col = 0; col < int'(ch_col_i); col++) begin
      for (b = 0; b < int'(batch_i); b++) begin
        lf  = (int'(pad_left_i) > w) ? int'(pad_left_i) - w : 0;
        tp  = (int'(pad_top_i) > h) ? int'(pad_top_i) - h : 0;
        rt  = (int'(pad_right_i) > fw - 1 - w) ? int'(pad_right_i) - (fw - 1 - w) : 0;
        bt  = (int'(pad_bottom_i) > fh - 1 - h) ? int'(pad_bottom_i) - (fh - 1 - h) : 0;
        d1  = int'(n_patches_w_i) - lf - rt;
        d2  = int'(n_patches_h_i) - tp - bt;
        row = (b * int'(num_ch_i) + c) * int'(ih_i) + (h - int'(pad_top_i)) + tp;
        idx = row * int'(iw_i) + (w - int'(pad_left_i)) + lf;
        d.in_ptr  = src_ptr_i + (32'(idx) << 2);
        d.out_ptr = dst_ptr_i + 32'(k * 4 * int'(n_patches_h_i) * int'(n_patches_w_i));
        d.inc_d2  = 16'(int'(iw_i) - (d1 - 1));
        d.size_d1 = 16'(d1);
        d.size_d2 = 16'(d2);
        d.left    = 8'(lf);
        d.right   = 8'(rt);
        d.top     = 8'(tp);
        d.bottom  = 8'(bt);
        exp_q.push_back(d);
        k++;
      end
      w++;                              // Window steps along the row first.
      if (w == fw) begin
        w = 0;
        h++;
        if (h == fh) begin
          h = 0;
          c++;
        end
      end
    end
  endtask

  // Descriptors are compared at the falling edge.
  always @(negedge clk_i) begin
    if (rst_ni && fifo_push_o) begin
      push_cnt++;
      check_true(!full_prev, "descriptor pushed right after a FIFO full cycle");
      check_true(exp_q.size() > 0, "push with no descriptor left in the model");
      if (exp_q.size() > 0) begin
        exp_d = exp_q.pop_front();
        check_field("desc_in_ptr_o", exp_d.in_ptr, desc_in_ptr_o);
        check_field("desc_out_ptr_o", exp_d.out_ptr, desc_out_ptr_o);
        check_field("desc_in_inc_d2_o", 32'(exp_d.inc_d2), 32'(desc_in_inc_d2_o));
        check_field("desc_size_d1_o", 32'(exp_d.size_d1), 32'(desc_size_d1_o));
        check_field("desc_size_d2_o", 32'(exp_d.size_d2), 32'(desc_size_d2_o));
        check_field("desc_zeros_left_o", 32'(exp_d.left), 32'(desc_zeros_left_o));
        check_field("desc_zeros_right_o", 32'(exp_d.right), 32'(desc_zeros_right_o));
        check_field("desc_zeros_top_o", 32'(exp_d.top), 32'(desc_zeros_top_o));
        check_field("desc_zeros_bottom_o", 32'(exp_d.bottom), 32'(desc_zeros_bottom_o));
      end
    end
    full_prev = fifo_full_i;
  end

  task automatic run_conv(input bit rand_full);
    int expected_cnt;
    expected_cnt = int'(ch_col_i) * int'(batch_i);
    build_expected();
    push_cnt = 0;
    start_i = 1'b1;
    @(posedge clk_i);
    #1 start_i = 1'b0;
    check_field("done_o", 32'(0), 32'(done_o));  // Cleared by start.
    while (!done_o) begin
      @(posedge clk_i);
      #1;
      if (rand_full) begin
        rng         = xorshift32(rng);
        fifo_full_i = rng[0];
      end
    end
    fifo_full_i = 1'b0;
    check_field("push count", 32'(expected_cnt), 32'(push_cnt));
    check_true(exp_q.size() == 0, "done_o rose before all descriptors were pushed");
    repeat (3) @(posedge clk_i);
    #1 check_field("done_o", 32'(1), 32'(done_o));
  endtask

  // Watchdog.
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < LIMIT) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("Simulation stopped after %0d cycles without finishing.", cycle_cnt);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    rst_ni      = 1'b0;
    start_i     = 1'b0;
    fifo_full_i = 1'b0;
    full_prev   = 1'b0;
    rng         = 32'h8874;
    errors      = 0;
    checks      = 0;
    push_cnt    = 0;
    set_config(1, 1, 2, 0, 4, 32'h1000_0000, 32'h2000_0000);  // Run A.
    repeat (3) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    repeat (5) begin
      @(posedge clk_i);
      #1;
      check_field("fifo_push_o", 32'(0), 32'(fifo_push_o));
      check_field("done_o", 32'(0), 32'(done_o));
    end
    run_conv(1'b0);
    set_config(3, 2, 2, 1, 8, 32'h0004_0000, 32'h0080_0000);  // Run B.
    run_conv(1'b0);
    run_conv(1'b1);                     // Run C repeats Run B under back-pressure.
    repeat (10) @(posedge clk_i);
    #1 check_field("done_o", 32'(1), 32'(done_o));
    errors = errors + i_dut.i_props.fail_cnt;
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
